/* build.f */
+incdir+tests
verilog/vcore_isa_pkg.sv
verilog/vcore_ctrl_pkg.sv
verilog/instruction_decode_unit.sv
verilog/execute_unit.sv
verilog/result_unit.sv
verilog/vector_core_top.sv
tests/vector_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vector_core_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/vector_core_model.svh */
`ifndef VECTOR_CORE_MODEL_SVH
`define VECTOR_CORE_MODEL_SVH

// opcode order of the stimulus table, 6'h33 is an unlisted code
localparam logic [5:0] OP_SEQ [NUM_VEC] = '{
    OP_VADD, OP_VSUB, OP_VMUL, OP_VSADD, OP_VSMUL, OP_IADD, OP_ISUB, OP_IAND,
    OP_IXOR, OP_IADDI, OP_NOP, OP_ICMP, OP_REDUCE, OP_VGET, OP_VPUT, OP_FCMP,
    OP_FADD, OP_FMUL, OP_ICMP, 6'h33, OP_VADD, OP_FCMP, OP_VGET, OP_IADDI
};

// expected record, flags are the ones in force before this instruction
function automatic vcore_result_t model_result(input vcore_instr_t ins,
                                               input logic [3:0] flags);
    vcore_result_t r;
    r.tag    = ins.tag;
    r.scalar = '0;
    r.vec    = ins.vec_a;
    {r.int_zero, r.int_neg, r.lane_zero, r.lane_neg} = flags;
    case (ins.opcode)
        OP_VADD:  for (int i = 0; i < LANES; i++) r.vec[i] = ins.vec_a[i] + ins.vec_b[i];
        OP_VSUB:  for (int i = 0; i < LANES; i++) r.vec[i] = ins.vec_a[i] - ins.vec_b[i];
        OP_VMUL:  for (int i = 0; i < LANES; i++) r.vec[i] = ins.vec_a[i] * ins.vec_b[i];
        OP_VSADD: for (int i = 0; i < LANES; i++) r.vec[i] = ins.vec_a[i] + ins.scalar_b;
        OP_VSMUL: for (int i = 0; i < LANES; i++) r.vec[i] = ins.vec_a[i] * ins.scalar_b;
        OP_FADD:  r.vec[0] = ins.scalar_a + ins.scalar_b;
        OP_FMUL:  r.vec[0] = ins.scalar_a * ins.scalar_b;
        OP_FCMP:  r.vec[0] = ins.scalar_a - ins.scalar_b;
        OP_REDUCE: begin
            // pair sums stay visible in lanes 0 and 2
            r.vec[0] = ins.vec_a[0] + ins.vec_a[1];
            r.vec[2] = ins.vec_a[2] + ins.vec_a[3];
            r.scalar = ins.vec_a[0] + ins.vec_a[1] + ins.vec_a[2] + ins.vec_a[3];
        end
        OP_VGET:  r.scalar = ins.vec_a[ins.imm];
        OP_VPUT:  r.vec[ins.imm] = ins.scalar_a;
        OP_IADD:  r.scalar = ins.scalar_a + ins.scalar_b;
        OP_ISUB,
        OP_ICMP:  r.scalar = ins.scalar_a - ins.scalar_b;
        OP_IAND:  r.scalar = ins.scalar_a & ins.scalar_b;
        OP_IXOR:  r.scalar = ins.scalar_a ^ ins.scalar_b;
        OP_IADDI: r.scalar = ins.scalar_a + {14'd0, ins.imm};
        default: ;
    endcase
    // float-path ops report lane 0 as the scalar
    if (ins.opcode inside {OP_FADD, OP_FMUL, OP_FCMP}) begin
        r.scalar = r.vec[0];
    end
    return r;
endfunction

// flag state after the instruction, order int_zero int_neg lane_zero lane_neg
function automatic logic [3:0] next_flags(input vcore_instr_t ins, input logic [3:0] flags);
    vcore_data_t diff;
    logic [3:0]  f;
    diff = ins.scalar_a - ins.scalar_b;
    f    = flags;
    if (ins.opcode == OP_ICMP) begin
        f[3:2] = {diff == '0, diff[DATA_W-1]};
    end
    if (ins.opcode == OP_FCMP) begin
        f[1:0] = {diff == '0, diff[DATA_W-1]};
    end
    return f;
endfunction

task automatic build_table();
    vcore_instr_t ins;
    logic [3:0]   flags;
    flags = '0;
    for (int n = 0; n < NUM_VEC; n++) begin
        for (int l = 0; l < LANES; l++) begin
            rng_state    = xorshift(rng_state);
            ins.vec_a[l] = rng_state[15:0];
            ins.vec_b[l] = rng_state[31:16];
        end
        rng_state    = xorshift(rng_state);
        ins.scalar_a = rng_state[15:0];
        ins.scalar_b = rng_state[31:16];
        rng_state    = xorshift(rng_state);
        ins.imm      = rng_state[1:0];
        ins.tag      = 4'(n);
        ins.opcode   = vcore_opcode_t'(OP_SEQ[n]);
        // edge operands for wrap and flag cases
        case (n)
            9: begin
                ins.scalar_a = 16'hffff;
                ins.imm      = 2'd3;
            end
            11: begin
                ins.scalar_a = 16'h8000;
                ins.scalar_b = 16'h8000;
            end
            12: begin
                ins.vec_a[0] = 16'h8000;
                ins.vec_a[1] = 16'h8000;
            end
            13: ins.imm = 2'd3;
            14: ins.imm = 2'd2;
            15: begin
                ins.scalar_a = 16'h8000;
                ins.scalar_b = 16'hffff;
            end
            18: begin
                ins.scalar_a = 16'h0000;
                ins.scalar_b = 16'h8000;
            end
            20: begin
                for (int l = 0; l < LANES; l++) begin
                    ins.vec_a[l] = 16'hffff;
                    ins.vec_b[l] = 16'h8000;
                end
            end
            21: begin
                ins.scalar_a = 16'hffff;
                ins.scalar_b = 16'hffff;
            end
            default: ;
        endcase
        instr_tab[n]  = ins;
        expect_tab[n] = model_result(ins, flags);
        flags         = next_flags(ins, flags);
    end
endtask

`endif

/* tests/vector_core_tb.sv */
`timescale 1ns/1ps

module vector_core_tb
    import vcore_isa_pkg::*, vcore_ctrl_pkg::*;
();

    localparam int NUM_VEC        = 24;
    localparam int STALL_AT       = 8;
    localparam int STALL_CYCLES   = 20;
    localparam int TIMEOUT_CYCLES = NUM_VEC * 40 + 200;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          in_valid;
    vcore_instr_t  in_instr;
    logic          in_credit;
    logic          out_valid;
    vcore_result_t out_result;
    logic          out_credit;

    vcore_instr_t  instr_tab  [NUM_VEC];
    vcore_result_t expect_tab [NUM_VEC];
    logic [31:0]   rng_state = 32'h95ba_f3e2;
    int            sent = 0;
    int            returns = 0;
    int            got_count = 0;
    int            credits_given = 0;
    int            cycles = 0;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    `include "vector_core_model.svh"

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_result(input vcore_result_t got, input vcore_result_t exp,
                                  input int n);
        check_value($sformatf("out_result[%0d].tag", n), got.tag, exp.tag);
        check_value($sformatf("out_result[%0d].scalar", n), got.scalar, exp.scalar);
        check_value($sformatf("out_result[%0d].vec", n), got.vec, exp.vec);
        check_value($sformatf("out_result[%0d].flags", n),
                    {got.int_zero, got.int_neg, got.lane_zero, got.lane_neg},
                    {exp.int_zero, exp.int_neg, exp.lane_zero, exp.lane_neg});
    endtask

    vector_core_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_credit (out_credit)
    );

    always #4 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        while (got_count < NUM_VEC) @(negedge clk);
        // room for a stray extra result to show up
        repeat (8) @(negedge clk);
        $display("TEST PASSED");
        $finish;
    end

    // producer spends its own credits
    initial begin
        int idx;
        idx      = 0;
        in_valid = 1'b0;
        in_instr = '0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);
        while (idx < NUM_VEC) begin
            @(posedge clk);
            if (IN_CREDITS - sent + returns > 0) begin
                in_valid <= 1'b1;
                in_instr <= instr_tab[idx];
                idx  = idx + 1;
                sent = sent + 1;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
    end

    // consumer grants one credit per expected result
    initial begin
        int gap;
        out_credit = 1'b0;
        @(posedge clk);
        while (!rst_n) @(posedge clk);
        for (int k = 0; k < NUM_VEC; k++) begin
            if (k == STALL_AT) begin
                // queue fills up and the producer runs dry
                repeat (STALL_CYCLES) @(posedge clk);
                @(negedge clk);
                check_value("producer credits", IN_CREDITS - sent + returns, 0);
            end
            rng_state = xorshift(rng_state);
            gap       = int'(rng_state[1:0]);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            out_credit <= 1'b1;
            credits_given = credits_given + 1;
            @(posedge clk);
            out_credit <= 1'b0;
        end
    end

    // mid-cycle sampling of the output side
    always @(negedge clk) begin
        if (rst_n) begin
            check_value("in_credit", in_credit, out_valid);
            if (credits_given <= got_count) begin
                check_value("out_valid", out_valid, 1'b0);
            end
            if (in_credit) begin
                returns = returns + 1;
            end
            if (out_valid) begin
                compare_result(out_result, expect_tab[got_count], got_count);
                got_count = got_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, results stopped arriving (%0d of %0d)",
                     cycles, got_count, NUM_VEC);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

endmodule

/* verilog/vector_core_top.sv */
`timescale 1ns/1ps

module vector_core_top
    import vcore_isa_pkg::*, vcore_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  vcore_instr_t  in_instr,
    output logic          in_credit,
    output logic          out_valid,
    output vcore_result_t out_result,
    input  logic          out_credit
);

    logic        dec_valid;
    vcore_ctrl_t dec_ctrl;
    logic        ex_valid;
    vcore_exec_t ex_data;

    instruction_decode_unit u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl)
    );

    execute_unit u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_ctrl  (dec_ctrl),
        .ex_valid  (ex_valid),
        .ex_data   (ex_data)
    );

    result_unit u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_data    (ex_data),
        .out_credit (out_credit),
        .out_valid  (out_valid),
        .out_result (out_result),
        .in_credit  (in_credit)
    );

endmodule

/* verilog/result_unit.sv */
`timescale 1ns/1ps

module result_unit
    import vcore_isa_pkg::*, vcore_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          ex_valid,
    input  vcore_exec_t   ex_data,
    input  logic          out_credit,
    output logic          out_valid,
    output vcore_result_t out_result,
    output logic          in_credit
);

    vcore_result_t             queue [RESULT_DEPTH];
    logic [QPTR_W-1:0]         wr_ptr;
    logic [QPTR_W-1:0]         rd_ptr;
    logic [QCNT_W-1:0]         q_count;
    logic [OUT_CREDIT_W-1:0]   credit_cnt;
    logic                      int_zero;
    logic                      int_neg;
    logic                      lane_zero;
    logic                      lane_neg;
    logic                      push;
    logic                      pop;
    vcore_data_t               lane_sum;
    vcore_data_t               scalar;
    vcore_result_t             rec;

    // last pairwise add of the reduction
    assign lane_sum = ex_data.reduce_en ? ex_data.lane_res[0] + ex_data.lane_res[2] : '0;

    always_comb begin
        case (ex_data.scalar_out_sel)
            SOUT_LANE0:    scalar = ex_data.lane_res[0];
            SOUT_LANE_IMM: scalar = ex_data.vec_a[ex_data.imm];
            SOUT_REDUCE:   scalar = lane_sum;
            default:       scalar = ex_data.int_res;
        endcase
    end

    // record carries the flags as they stood before this instruction
    always_comb begin
        rec.tag       = ex_data.tag;
        rec.scalar    = scalar;
        rec.vec       = ex_data.lane_res;
        rec.int_zero  = int_zero;
        rec.int_neg   = int_neg;
        rec.lane_zero = lane_zero;
        rec.lane_neg  = lane_neg;
    end

    assign push       = ex_valid;
    assign pop        = (q_count != '0) && (credit_cnt != '0);
    assign out_valid  = pop;
    assign in_credit  = pop;
    assign out_result = queue[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_zero  <= 1'b0;
            int_neg   <= 1'b0;
            lane_zero <= 1'b0;
            lane_neg  <= 1'b0;
        end else if (ex_valid) begin
            if (ex_data.update_int_flag) begin
                int_zero <= (ex_data.int_res == '0);
                int_neg  <= ex_data.int_res[DATA_W-1];
            end
            if (ex_data.update_lane_flag) begin
                lane_zero <= (ex_data.lane_res[0] == '0);
                lane_neg  <= ex_data.lane_res[0][DATA_W-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= rec;
        end
    end

    // queue pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(RESULT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(RESULT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // output credits granted by the consumer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= '0;
        end else begin
            case ({out_credit, pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
    import vcore_isa_pkg::*, vcore_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dec_valid,
    input  vcore_ctrl_t dec_ctrl,
    output logic        ex_valid,
    output vcore_exec_t ex_data
);

    vcore_data_t int_op2;
    vcore_data_t int_res;
    vcore_vec_t  lane_op1;
    vcore_vec_t  lane_op2;
    vcore_vec_t  lane_res;
    vcore_exec_t ex_next;

    // shared by the int ALU and the lane ALUs, wraps at DATA_W
    function automatic vcore_data_t alu(input alu_fn_t fn,
                                        input vcore_data_t a,
                                        input vcore_data_t b);
        logic [2*DATA_W-1:0] prod;
        vcore_data_t         res;
        prod = a * b;
        case (fn)
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_MUL:  res = prod[DATA_W-1:0];
            FN_AND:  res = a & b;
            FN_XOR:  res = a ^ b;
            default: res = a;
        endcase
        return res;
    endfunction

    always_comb begin
        // int ALU, op1 is always scalar a
        int_op2 = (dec_ctrl.int_op2_sel == SEL_IMM) ? DATA_W'(dec_ctrl.imm)
                                                    : dec_ctrl.instr.scalar_b;
        int_res = dec_ctrl.int_en ? alu(dec_ctrl.int_fn, dec_ctrl.instr.scalar_a, int_op2)
                                  : '0;

        for (int i = 0; i < LANES; i++) begin
            lane_op1[i] = (dec_ctrl.lane_op1_sel[i] == SEL_SCALAR_A) ? dec_ctrl.instr.scalar_a
                                                                     : dec_ctrl.instr.vec_a[i];
            case (dec_ctrl.lane_op2_sel[i])
                SEL_SCALAR_B:   lane_op2[i] = dec_ctrl.instr.scalar_b;
                SEL_VEC_A_NEXT: lane_op2[i] = dec_ctrl.instr.vec_a[i | 1];
                default:        lane_op2[i] = dec_ctrl.instr.vec_b[i];
            endcase
            // idle lanes hand vector a through
            lane_res[i] = dec_ctrl.lane_en[i] ? alu(dec_ctrl.lane_fn, lane_op1[i], lane_op2[i])
                                              : dec_ctrl.instr.vec_a[i];
        end
    end

    always_comb begin
        ex_next.tag              = dec_ctrl.instr.tag;
        ex_next.scalar_out_sel   = dec_ctrl.scalar_out_sel;
        ex_next.imm              = dec_ctrl.imm;
        ex_next.update_int_flag  = dec_ctrl.update_int_flag;
        ex_next.update_lane_flag = dec_ctrl.update_lane_flag;
        ex_next.reduce_en        = dec_ctrl.reduce_en;
        ex_next.int_res          = int_res;
        ex_next.lane_res         = lane_res;
        ex_next.vec_a            = dec_ctrl.instr.vec_a;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_data <= ex_next;
    end

endmodule

/* verilog/instruction_decode_unit.sv */
`timescale 1ns/1ps

module instruction_decode_unit
    import vcore_isa_pkg::*, vcore_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  vcore_instr_t in_instr,
    output logic         dec_valid,
    output vcore_ctrl_t  dec_ctrl
);

    vcore_ctrl_t ctrl;

    always_comb begin
        // everything off, lanes read their own elements
        ctrl.int_en           = 1'b0;
        ctrl.int_fn           = FN_ADD;
        ctrl.int_op2_sel      = SEL_INT_SCALAR_B;
        ctrl.lane_en          = '0;
        ctrl.lane_fn          = FN_PASS;
        ctrl.scalar_out_sel   = SOUT_INT;
        ctrl.imm              = in_instr.imm;
        ctrl.update_int_flag  = 1'b0;
        ctrl.update_lane_flag = 1'b0;
        ctrl.reduce_en        = 1'b0;
        ctrl.instr            = in_instr;
        for (int i = 0; i < LANES; i++) begin
            ctrl.lane_op1_sel[i] = SEL_VEC_A_LANE;
            ctrl.lane_op2_sel[i] = SEL_VEC_B_LANE;
        end

        case (in_instr.opcode)
            // vector-vector
            OP_VADD, OP_VSUB, OP_VMUL: begin
                ctrl.lane_en = '1;
                ctrl.lane_fn = (in_instr.opcode == OP_VADD) ? FN_ADD :
                               (in_instr.opcode == OP_VSUB) ? FN_SUB : FN_MUL;
            end
            // scalar b broadcast to every lane
            OP_VSADD, OP_VSMUL: begin
                ctrl.lane_en = '1;
                ctrl.lane_fn = (in_instr.opcode == OP_VSADD) ? FN_ADD : FN_MUL;
                for (int i = 0; i < LANES; i++) begin
                    ctrl.lane_op2_sel[i] = SEL_SCALAR_B;
                end
            end
            // scalar float path runs on lane 0
            OP_FADD, OP_FMUL, OP_FCMP: begin
                ctrl.lane_en[0]      = 1'b1;
                ctrl.lane_op1_sel[0] = SEL_SCALAR_A;
                ctrl.lane_op2_sel[0] = SEL_SCALAR_B;
                ctrl.scalar_out_sel  = SOUT_LANE0;
                case (in_instr.opcode)
                    OP_FADD: ctrl.lane_fn = FN_ADD;
                    OP_FMUL: ctrl.lane_fn = FN_MUL;
                    default: begin
                        ctrl.lane_fn          = FN_SUB;
                        ctrl.update_lane_flag = 1'b1;
                    end
                endcase
            end
            // lanes 0 and 2 add their odd neighbours, result stage finishes
            OP_REDUCE: begin
                ctrl.lane_en[0]      = 1'b1;
                ctrl.lane_en[2]      = 1'b1;
                ctrl.lane_op2_sel[0] = SEL_VEC_A_NEXT;
                ctrl.lane_op2_sel[2] = SEL_VEC_A_NEXT;
                ctrl.lane_fn         = FN_ADD;
                ctrl.reduce_en       = 1'b1;
                ctrl.scalar_out_sel  = SOUT_REDUCE;
            end
            OP_VGET: begin
                ctrl.scalar_out_sel = SOUT_LANE_IMM;
            end
            // only the named lane takes scalar a
            OP_VPUT: begin
                ctrl.lane_en[in_instr.imm]      = 1'b1;
                ctrl.lane_op1_sel[in_instr.imm] = SEL_SCALAR_A;
                ctrl.lane_fn                    = FN_PASS;
            end
            OP_IADD, OP_ISUB, OP_IAND, OP_IXOR, OP_ICMP: begin
                ctrl.int_en = 1'b1;
                case (in_instr.opcode)
                    OP_IADD: ctrl.int_fn = FN_ADD;
                    OP_IAND: ctrl.int_fn = FN_AND;
                    OP_IXOR: ctrl.int_fn = FN_XOR;
                    default: ctrl.int_fn = FN_SUB;
                endcase
                ctrl.update_int_flag = (in_instr.opcode == OP_ICMP);
            end
            OP_IADDI: begin
                ctrl.int_en      = 1'b1;
                ctrl.int_fn      = FN_ADD;
                ctrl.int_op2_sel = SEL_IMM;
            end
            // sqrt, memory and context switch land here too
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        dec_ctrl <= ctrl;
    end

endmodule

/* verilog/vcore_ctrl_pkg.sv */
package vcore_ctrl_pkg;
    import vcore_isa_pkg::*;

    typedef enum logic {SEL_INT_SCALAR_B, SEL_IMM} int_op2_sel_t;
    typedef enum logic {SEL_VEC_A_LANE, SEL_SCALAR_A} lane_op1_sel_t;
    // vec_a_next pairs a lane with its odd neighbour
    typedef enum logic [1:0] {SEL_VEC_B_LANE, SEL_SCALAR_B, SEL_VEC_A_NEXT} lane_op2_sel_t;
    typedef enum logic [2:0] {FN_ADD, FN_SUB, FN_MUL, FN_AND, FN_XOR, FN_PASS} alu_fn_t;
    typedef enum logic [1:0] {SOUT_INT, SOUT_LANE0, SOUT_LANE_IMM, SOUT_REDUCE} scalar_out_sel_t;

    typedef struct packed {
        logic                          int_en;
        alu_fn_t                       int_fn;
        int_op2_sel_t                  int_op2_sel;
        logic [LANES-1:0]              lane_en;
        lane_op1_sel_t [LANES-1:0]     lane_op1_sel;
        lane_op2_sel_t [LANES-1:0]     lane_op2_sel;
        alu_fn_t                       lane_fn;
        scalar_out_sel_t               scalar_out_sel;
        logic [IMM_W-1:0]              imm;
        logic                          update_int_flag;
        logic                          update_lane_flag;
        logic                          reduce_en;
        vcore_instr_t                  instr;
    } vcore_ctrl_t;

    // what the result stage needs from execute
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        scalar_out_sel_t   scalar_out_sel;
        logic [IMM_W-1:0]  imm;
        logic              update_int_flag;
        logic              update_lane_flag;
        logic              reduce_en;
        vcore_data_t       int_res;
        vcore_vec_t        lane_res;
        vcore_vec_t        vec_a;
    } vcore_exec_t;

    localparam int RESULT_DEPTH = 4;
    localparam int IN_CREDITS   = RESULT_DEPTH;
    localparam int QPTR_W       = $clog2(RESULT_DEPTH);
    localparam int QCNT_W       = $clog2(RESULT_DEPTH + 1);
    localparam int OUT_CREDIT_W = 8;

endpackage

/* verilog/vcore_isa_pkg.sv */
package vcore_isa_pkg;

    localparam int LANES  = 4;
    localparam int DATA_W = 16;
    localparam int TAG_W  = 4;
    localparam int IMM_W  = 2;

    typedef logic [DATA_W-1:0] vcore_data_t;
    typedef vcore_data_t [LANES-1:0] vcore_vec_t;

    // opcode class lives in the upper bits
    typedef enum logic [5:0] {
        OP_VADD   = 6'b000000,
        OP_VSUB   = 6'b000001,
        OP_VMUL   = 6'b000010,
        OP_VSADD  = 6'b001000,
        OP_VSMUL  = 6'b001010,
        OP_FADD   = 6'b010000,
        OP_FMUL   = 6'b010010,
        OP_FCMP   = 6'b010101,
        OP_IADD   = 6'b011000,
        OP_ISUB   = 6'b011001,
        OP_IAND   = 6'b011010,
        OP_IXOR   = 6'b011011,
        OP_ICMP   = 6'b011101,
        OP_IADDI  = 6'b100000,
        OP_REDUCE = 6'b100100,
        OP_VGET   = 6'b100101,
        OP_VPUT   = 6'b100111,
        OP_NOP    = 6'b111111
    } vcore_opcode_t;

    // one instruction with its operands
    typedef struct packed {
        vcore_opcode_t     opcode;
        logic [IMM_W-1:0]  imm;
        logic [TAG_W-1:0]  tag;
        vcore_data_t       scalar_a;
        vcore_data_t       scalar_b;
        vcore_vec_t        vec_a;
        vcore_vec_t        vec_b;
    } vcore_instr_t;

    // record handed to the consumer
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        vcore_data_t       scalar;
        vcore_vec_t        vec;
        logic              int_zero;
        logic              int_neg;
        logic              lane_zero;
        logic              lane_neg;
    } vcore_result_t;

endpackage
